// File: include/stt8_macros.svh
`ifndef STT8_MACROS_SVH
`define STT8_MACROS_SVH

// Horizontal timing in pixel clocks, 640x480 at 60 Hz
`define STT8_H_ACTIVE 640  // Visible pixels
`define STT8_H_FRONT  16   // Front porch
`define STT8_H_SYNC   96   // Sync pulse width
`define STT8_H_TOTAL  800  // Full line incl. back porch

// Vertical timing in lines
`define STT8_V_ACTIVE 480  // Visible lines
`define STT8_V_FRONT  10   // Front porch
`define STT8_V_SYNC   2    // Sync pulse width
`define STT8_V_TOTAL  525  // Full frame incl. back porch

// Tile geometry
`define STT8_TILE_PX  32   // 8x8 sprite scaled by four
`define STT8_NUM_ENT  9    // Entity slots in the table
`define STT8_ID_NONE  15   // Empty slot marker

`endif

// File: verilog/video_pkg.sv
package video_pkg;

  // Pixel or line position, wide enough for 800 and 525
  typedef logic [9:0] pix_count_t;

  // Horizontal phase of the current pixel
  typedef enum logic [1:0] {
    ACTIVE, // Visible region
    FRONT,  // Front porch
    SYNC,   // Sync pulse
    BACK    // Back porch
  } sync_state_e;

  // Both syncs are active low
  localparam logic SYNC_ON  = 1'b0;
  localparam logic SYNC_OFF = 1'b1;

endpackage

// File: verilog/sprite_pkg.sv
package sprite_pkg;

  // Rotation, clockwise from the stored bitmap
  typedef enum logic [1:0] {
    ORIENT_UP    = 2'd0, // As stored
    ORIENT_RIGHT = 2'd1, // 90 deg
    ORIENT_DOWN  = 2'd2, // 180 deg
    ORIENT_LEFT  = 2'd3  // 270 deg
  } orient_e;

  // Descriptor, 14 bits, same packing as the entity bus
  typedef struct packed {
    logic [3:0] id;     // Sprite index, 15 = empty
    orient_e    orient;
    logic [3:0] row;    // Tile row
    logic [3:0] col;    // Tile column
  } entity_t;

  // Bit row*8+col, row 0 in the low byte
  localparam logic [63:0] SPRITE_TABLE [16] = '{
    64'h18181818_FF7E3C18, 64'h00020202_3E02027E, 64'h007E0202_02020202,
    64'h00020202_3E42423E, 64'hFF818181_818181FF, 64'hAA55AA55_AA55AA55,
    64'h80402010_08040201, 64'h0103070F_1F3F7FFF, 64'h00422212_3E42423E,
    64'h0000000E_08040000, 64'h00241818_3C7E5A18, 64'hC3E77E3C_3C7EE7C3,
    64'h0F0F0F0F_00000000, 64'h01010101_010101FF, 64'hFFFFFFFF_FFFFFFFF,
    64'h00000000_00000000
  };

endpackage

// File: verilog/stt8_ifs.sv
`timescale 1ns/1ps

// Raster position and sync from the timing generator
interface video_if;
  video_pkg::pix_count_t h_count; // Pixel in line
  video_pkg::pix_count_t v_count; // Line in frame
  logic                  active;  // Inside 640x480
  logic                  hsync;   // Active low
  logic                  vsync;   // Active low

  modport src (
    output h_count, v_count, active, hsync, vsync
  );

  modport snk (
    input h_count, v_count, active, hsync, vsync
  );
endinterface

// Sprite lookup, request in one cycle and pixel the next
interface sprite_if;
  logic [3:0]          id;     // Sprite index
  sprite_pkg::orient_e orient; // Rotation
  logic                mirror; // Horizontal flip after rotation
  logic [2:0]          px_x;   // Column within sprite
  logic [2:0]          px_y;   // Row within sprite
  logic                pixel;  // Registered lookup result

  modport req (
    output id, orient, mirror, px_x, px_y,
    input  pixel
  );

  modport rom (
    input  id, orient, mirror, px_x, px_y,
    output pixel
  );
endinterface

// File: verilog/vga_timing.sv
`timescale 1ns/1ps
`include "stt8_macros.svh"

module vga_timing (
  input  logic clk,
  input  logic arst_n,
  video_if.src vid
);

  video_pkg::pix_count_t  h_count; // Pixel in line
  video_pkg::pix_count_t  v_count; // Line in frame
  video_pkg::sync_state_e h_state; // Phase of the pixel at h_count
  logic                   h_last;  // Last pixel of line
  logic                   v_last;  // Last line of frame

  assign h_last = (h_count == 10'(`STT8_H_TOTAL - 1));
  assign v_last = (v_count == 10'(`STT8_V_TOTAL - 1));

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      h_count <= '0;
      v_count <= '0;
    end else begin
      h_count <= h_last ? '0 : h_count + 10'd1; // Free running, no stall
      if (h_last) begin
        v_count <= v_last ? '0 : v_count + 10'd1;
      end
    end
  end

  // Next phase chosen on the last pixel of the current one
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      h_state <= video_pkg::ACTIVE;
    end else begin
      case (h_state)
        video_pkg::ACTIVE: if (h_count == 10'(`STT8_H_ACTIVE - 1)) h_state <= video_pkg::FRONT;
        video_pkg::FRONT:
          if (h_count == 10'(`STT8_H_ACTIVE + `STT8_H_FRONT - 1)) h_state <= video_pkg::SYNC;
        video_pkg::SYNC: if (h_count == 10'(`STT8_H_ACTIVE + `STT8_H_FRONT + `STT8_H_SYNC - 1)) begin
          h_state <= video_pkg::BACK;
        end
        default: if (h_last) h_state <= video_pkg::ACTIVE; // End of back porch
      endcase
    end
  end

  assign vid.h_count = h_count;
  assign vid.v_count = v_count;
  assign vid.active  = (h_state == video_pkg::ACTIVE) && (v_count < 10'(`STT8_V_ACTIVE));
  assign vid.hsync   = (h_state == video_pkg::SYNC) ? video_pkg::SYNC_ON : video_pkg::SYNC_OFF;
  // Lines 490 and 491
  assign vid.vsync   = (v_count >= 10'(`STT8_V_ACTIVE + `STT8_V_FRONT) &&
                        v_count <  10'(`STT8_V_ACTIVE + `STT8_V_FRONT + `STT8_V_SYNC)) ?
                       video_pkg::SYNC_ON : video_pkg::SYNC_OFF;

endmodule

// File: verilog/entity_table.sv
`timescale 1ns/1ps
`include "stt8_macros.svh"

module entity_table (
  input  logic                clk,
  input  logic                arst_n,
  input  logic                ent_we,                   // Single-cycle write strobe
  input  logic [3:0]          ent_idx,                  // Slot to write
  input  sprite_pkg::entity_t ent_data,                 // New descriptor
  output sprite_pkg::entity_t entities [`STT8_NUM_ENT]  // Held descriptors
);

  logic idx_ok; // Index inside the table

  assign idx_ok = (ent_idx < 4'(`STT8_NUM_ENT));

  // Visible to the frame buffer on the cycle after the strobe
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      for (int i = 0; i < `STT8_NUM_ENT; i++) begin
        entities[i] <= '{
          id:     4'(`STT8_ID_NONE), // Slot empty
          orient: sprite_pkg::ORIENT_UP,
          row:    4'd0,
          col:    4'd0
        };
      end
    end else if (ent_we && idx_ok) begin
      entities[ent_idx] <= ent_data; // Indices 9..15 dropped
    end
  end

endmodule

// File: verilog/sprite_rom.sv
`timescale 1ns/1ps

module sprite_rom (
  input  logic  clk,
  input  logic  arst_n,
  sprite_if.rom spr
);

  logic [2:0]  fx;     // Screen x with mirror undone
  logic [2:0]  src_x;  // Column in stored bitmap
  logic [2:0]  src_y;  // Row in stored bitmap
  logic [63:0] bitmap; // Selected sprite

  // Mirror applies to the rotated image, so flip x before undoing rotation
  assign fx = spr.mirror ? 3'd7 - spr.px_x : spr.px_x;

  // Screen coordinate back to stored coordinate
  always_comb begin
    src_x = fx;
    src_y = spr.px_y;
    case (spr.orient)
      sprite_pkg::ORIENT_RIGHT: begin
        src_x = spr.px_y;      // Top row lands in right column
        src_y = 3'd7 - fx;
      end
      sprite_pkg::ORIENT_DOWN: begin
        src_x = 3'd7 - fx;     // Both axes reversed
        src_y = 3'd7 - spr.px_y;
      end
      sprite_pkg::ORIENT_LEFT: begin
        src_x = 3'd7 - spr.px_y; // Top row lands in left column
        src_y = fx;
      end
      default: begin
        src_x = fx;            // Upright
        src_y = spr.px_y;
      end
    endcase
  end

  assign bitmap = sprite_pkg::SPRITE_TABLE[spr.id];

  // Pipeline stage 2
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      spr.pixel <= 1'b0;
    end else begin
      spr.pixel <= bitmap[{src_y, src_x}];
    end
  end

endmodule

// File: verilog/frame_buffer.sv
`timescale 1ns/1ps
`include "stt8_macros.svh"

module frame_buffer (
  input  logic                clk,
  input  logic                arst_n,
  video_if.snk                vid,
  sprite_if.req               spr,
  input  sprite_pkg::entity_t entities [`STT8_NUM_ENT],
  output logic                colour,
  output logic                hsync,
  output logic                vsync,
  output logic                de
);

  logic [3:0] tile_row; // 32-line band
  logic [3:0] tile_col; // 32-pixel column
  logic       in_grid;  // Left 512 pixels only
  logic       hit;      // Some entity owns this tile
  logic [3:0] hit_idx;  // Lowest owning entity
  logic       s1_valid; // Draw flag, stage 1
  logic       s2_valid; // Draw flag, stage 2
  logic [1:0] hsync_d;  // Sync and active delay, stages 1 and 2
  logic [1:0] vsync_d;
  logic [1:0] active_d;

  assign tile_row = vid.v_count[8:5];
  assign tile_col = vid.h_count[8:5];
  assign in_grid  = (vid.h_count < 10'(`STT8_TILE_PX * 16));

  // Priority encoder, scanning down so index 0 wins
  always_comb begin
    hit     = 1'b0;
    hit_idx = '0;
    for (int i = `STT8_NUM_ENT - 1; i >= 0; i--) begin
      if (entities[i].id != 4'(`STT8_ID_NONE) &&
          entities[i].row == tile_row && entities[i].col == tile_col) begin
        hit     = 1'b1;
        hit_idx = 4'(i);
      end
    end
  end

  // Stage 1 request, scaled by four via counter bits 4:2
  always_ff @(posedge clk) begin
    spr.id     <= entities[hit_idx].id;
    spr.orient <= entities[hit_idx].orient;
    spr.mirror <= (hit_idx >= 4'(`STT8_NUM_ENT - 2)); // Last two slots flipped
    spr.px_x   <= vid.h_count[4:2];
    spr.px_y   <= vid.v_count[4:2];
  end

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      s1_valid <= 1'b0;
      s2_valid <= 1'b0;
      hsync_d  <= {2{video_pkg::SYNC_OFF}};
      vsync_d  <= {2{video_pkg::SYNC_OFF}};
      active_d <= 2'b00;
      colour   <= 1'b0;
      hsync    <= video_pkg::SYNC_OFF;
      vsync    <= video_pkg::SYNC_OFF;
      de       <= 1'b0;
    end else begin
      s1_valid <= hit && in_grid && vid.active; // Also blanks outside video
      s2_valid <= s1_valid;                     // Alongside ROM read
      hsync_d  <= {hsync_d[0], vid.hsync};
      vsync_d  <= {vsync_d[0], vid.vsync};
      active_d <= {active_d[0], vid.active};
      colour   <= spr.pixel & s2_valid; // Stage 3
      hsync    <= hsync_d[1];
      vsync    <= vsync_d[1];
      de       <= active_d[1];
    end
  end

endmodule

// File: verilog/stt8_top.sv
`timescale 1ns/1ps
`include "stt8_macros.svh"

module stt8_top (
  input  logic        clk,
  input  logic        arst_n,
  input  logic        ent_we,   // Entity write strobe
  input  logic [3:0]  ent_idx,  // Entity slot
  input  logic [13:0] ent_data, // {id, orient, row, col}
  output logic        colour,   // One-bit pixel
  output logic        hsync,    // Active low
  output logic        vsync,    // Active low
  output logic        de        // Display enable
);

  video_if  vid (); // Timing to frame buffer
  sprite_if spr (); // Frame buffer to ROM

  sprite_pkg::entity_t entities [`STT8_NUM_ENT]; // Table contents

  vga_timing u_vga_timing (
    .clk    (clk),
    .arst_n (arst_n),
    .vid    (vid)
  );

  entity_table u_entity_table (
    .clk      (clk),
    .arst_n   (arst_n),
    .ent_we   (ent_we),
    .ent_idx  (ent_idx),
    .ent_data (sprite_pkg::entity_t'(ent_data)),
    .entities (entities)
  );

  frame_buffer u_frame_buffer (
    .clk      (clk),
    .arst_n   (arst_n),
    .vid      (vid),
    .spr      (spr),
    .entities (entities),
    .colour   (colour),
    .hsync    (hsync),
    .vsync    (vsync),
    .de       (de)
  );

  sprite_rom u_sprite_rom (
    .clk    (clk),
    .arst_n (arst_n),
    .spr    (spr)
  );

endmodule

// File: verif/stt8_tb.sv
`timescale 1ns/1ps
`include "stt8_macros.svh"

module stt8_tb;

  localparam int     FRAMES     = 11; // Whole run plus one spare frame
  localparam longint TIMEOUT_NS = longint'(FRAMES) * `STT8_H_TOTAL * `STT8_V_TOTAL * 20 * 3 / 2;

  logic        clk = 1'b0;
  logic        arst_n;
  logic        ent_we;
  logic [3:0]  ent_idx;
  logic [13:0] ent_data;
  logic        colour;
  logic        hsync;
  logic        vsync;
  logic        de;

  sprite_pkg::entity_t ent_model [`STT8_NUM_ENT]; // Expected table contents
  int   errors = 0;
  int   checks = 0;
  int   seed   = 32'h02e0978d;
  int   x = 0;                                     // Raster position at the outputs
  int   y = -1;
  int   line_len = 0;
  int   hs_len = 0;
  int   vs_len = 0;
  int   de_len = 0;
  logic hs_prev = 1'b1;
  logic vs_prev = 1'b1;
  logic de_prev = 1'b0;
  bit   framed = 1'b0;                             // Seen a vsync pulse
  bit   line_seen = 1'b0;

  stt8_top DUT (
    .clk      (clk),
    .arst_n   (arst_n),
    .ent_we   (ent_we),
    .ent_idx  (ent_idx),
    .ent_data (ent_data),
    .colour   (colour),
    .hsync    (hsync),
    .vsync    (vsync),
    .de       (de)
  );

  always #10 clk = ~clk; // 50 MHz pixel clock

  function automatic sprite_pkg::entity_t make_entity(input int id, input int orient,
                                                      input int row, input int col);
    return '{id: 4'(id), orient: sprite_pkg::orient_e'(orient), row: 4'(row), col: 4'(col)};
  endfunction

  // Colour of one screen pixel from the tile, priority and orientation rules
  function automatic logic expected_pixel(input sprite_pkg::entity_t ents [`STT8_NUM_ENT],
                                          input int px, input int py);
    int sel;
    int sx;
    int sy;
    int r;
    int c;
    sel = -1;
    if (px >= `STT8_TILE_PX * 16) return 1'b0; // Right of the tile grid
    for (int i = 0; i < `STT8_NUM_ENT; i++) begin
      if (sel < 0 && ents[i].id != `STT8_ID_NONE &&
          ents[i].row == py / `STT8_TILE_PX && ents[i].col == px / `STT8_TILE_PX) sel = i;
    end
    if (sel < 0) return 1'b0;
    sx = (px % `STT8_TILE_PX) / 4; // Scale by four
    sy = (py % `STT8_TILE_PX) / 4;
    if (sel >= 7) sx = 7 - sx;     // Entities 8 and 9 flipped after rotation
    // Odd orientations swap axes, then reverse per quarter turn
    r = ents[sel].orient[0] ? sx : sy;
    c = ents[sel].orient[0] ? sy : sx;
    if (ents[sel].orient inside {sprite_pkg::ORIENT_RIGHT, sprite_pkg::ORIENT_DOWN}) r = 7 - r;
    if (ents[sel].orient inside {sprite_pkg::ORIENT_DOWN, sprite_pkg::ORIENT_LEFT}) c = 7 - c;
    return sprite_pkg::SPRITE_TABLE[ents[sel].id][r * 8 + c];
  endfunction

  task automatic check_value(input logic [31:0] got, input logic [31:0] exp, input string msg);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("MISMATCH at %0t ns: %s got %0d expected %0d", $time, msg, got, exp);
    end
  endtask

  task automatic write_entity(input int idx, input sprite_pkg::entity_t e);
    @(posedge clk);
    ent_we   <= 1'b1;
    ent_idx  <= 4'(idx);
    ent_data <= e;
    @(posedge clk);
    ent_we   <= 1'b0;
    if (idx < `STT8_NUM_ENT) ent_model[idx] = e; // Out-of-range slots dropped
  endtask

  // Output monitor sampled mid-cycle
  always @(negedge clk) begin
    if (arst_n) begin
      line_len++;
      if (!hsync && hs_prev) begin
        if (line_seen) check_value(line_len, `STT8_H_TOTAL, "line period");
        line_seen = 1'b1;
        line_len  = 0;
      end
      if (hsync && !hs_prev) begin
        check_value(hs_len, `STT8_H_SYNC, "hsync width");
        hs_len = 0;
      end
      if (!hsync) hs_len++;
      if (!vsync && vs_prev) begin // New frame begins after this pulse
        if (framed) check_value(y + 1, `STT8_V_ACTIVE, "de lines per frame");
        framed = 1'b1;
        y      = -1;
      end
      if (vsync && !vs_prev) begin
        check_value(vs_len, `STT8_V_SYNC * `STT8_H_TOTAL, "vsync width");
        vs_len = 0;
      end
      if (!vsync) vs_len++;
      if (de && !de_prev) begin // Line start
        y++;
        x = 0;
      end
      if (!de && de_prev) begin
        check_value(de_len, `STT8_H_ACTIVE, "de span");
        de_len = 0;
      end
      if (de) begin
        de_len++;
        if (framed) begin
          check_value(colour, expected_pixel(ent_model, x, y), $sformatf("pixel (%0d,%0d)", x, y));
        end
        x++;
      end else begin
        check_value(colour, 0, "colour outside de");
      end
      hs_prev = hsync;
      vs_prev = vsync;
      de_prev = de;
    end
  end

  initial begin
    #(TIMEOUT_NS);
    $display("Timeout: the frame sequence did not finish in time");
    $display("Test FAILED");
    $finish;
  end

  initial begin
    int rnd;
    arst_n   = 1'b0;
    ent_we   = 1'b0;
    ent_idx  = 4'd0;
    ent_data = 14'd0;
    for (int i = 0; i < `STT8_NUM_ENT; i++) ent_model[i] = make_entity(`STT8_ID_NONE, 0, 0, 0);
    repeat (4) @(posedge clk);
    arst_n <= 1'b1;
    @(negedge vsync); // Next frame stays blank
    for (int o = 0; o < 4; o++) begin
      @(negedge vsync); // Loads only in vertical blanking
      write_entity(0, make_entity(1, o, 3, 5));
    end
    @(negedge vsync);
    write_entity(0, make_entity(`STT8_ID_NONE, 0, 0, 0));
    write_entity(1, make_entity(2, 1, 1, 2));
    write_entity(8, make_entity(2, 1, 1, 6)); // Flipped copy
    @(negedge vsync);
    write_entity(2, make_entity(7, 0, 4, 4));
    write_entity(3, make_entity(11, 2, 4, 4));            // Hidden under slot 2
    write_entity(4, make_entity(`STT8_ID_NONE, 0, 5, 5)); // Empty slot above slot 6
    write_entity(6, make_entity(4, 0, 5, 5));             // Box shows through the empty slot
    write_entity(5, make_entity(3, 0, 2, 0));             // Also aliases x 512..543
    write_entity(12, make_entity(4, 0, 6, 6));            // Must be ignored
    for (int f = 0; f < 2; f++) begin
      @(negedge vsync);
      for (int i = 0; i < `STT8_NUM_ENT; i++) begin
        rnd = $random(seed);
        write_entity(i, make_entity(rnd[3:0], rnd[5:4], rnd[9:6] % 15, rnd[13:10]));
      end
    end
    @(negedge vsync); // Last frame fully compared
    if (checks == 0) begin
      $display("ERROR: no output pixels were compared");
      errors++;
    end
    $display("Checks: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("Test OK");
    end else begin
      $display("Test FAILED");
    end
    $finish;
  end

endmodule

// File: verilog.f
+incdir+include
verilog/video_pkg.sv
verilog/sprite_pkg.sv
verilog/stt8_ifs.sv
verilog/vga_timing.sv
verilog/entity_table.sv
verilog/sprite_rom.sv
verilog/frame_buffer.sv
verilog/stt8_top.sv
verif/stt8_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Build with Verilator and run, pass only when the testbench prints its pass line
cd "$(dirname "$0")" || exit 1
verilator --binary --timing -Wno-fatal -f verilog.f --top-module stt8_tb -o stt8_sim \
  && out=$(./obj_dir/stt8_sim) \
  || { echo "$out"; echo "Build or simulation failed"; exit 1; }
echo "$out"
echo "$out" | grep -qx "Test OK" && exit 0 || exit 1
